/* hdl/cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Data RAM inside the memory stage, in 32-bit words
`define CPU_DMEM_WORDS 256

// First fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

// Byte offset bits below the word index
`define CPU_WORD_OFFSET 2

// The ROM is addressed by word, so rom_address is pc shifted by this amount
// and the data RAM index starts at the same bit

`endif

/* hdl/cpu_pkg.sv */
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // RV32I major opcodes handled by decode
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B  // LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_LINK
    } wb_sel_e;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        logic     branch;
        logic     branch_ne;    // BNE when set, BEQ otherwise
        logic     jump;
        logic     alu_src_imm;
        alu_op_e  alu_op;
        wb_sel_e  wb_sel;
        word_t    imm;
        word_t    rs1_value;
        word_t    rs2_value;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
        wb_sel_e  wb_sel;
        word_t    result;       // ALU result, also the load/store address
        word_t    store_data;
        word_t    link;         // pc + 4
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } retire_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

endpackage

/* hdl/fetch.sv */
`include "cpu_params.svh"

module fetch (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                enable,
    input  logic                hold,
    input  cpu_pkg::redirect_t  redirect,
    output cpu_pkg::word_t      rom_address,
    input  cpu_pkg::word_t      rom_data,
    output cpu_pkg::if_id_t     if_id
);

    cpu_pkg::word_t pc;
    cpu_pkg::word_t pc_next;

    assign rom_address = pc >> `CPU_WORD_OFFSET;  // ROM is word addressed

    always_comb begin
        if (redirect.valid) begin
            pc_next = redirect.target;
        end else if (hold) begin
            pc_next = pc;                       // Refetch after the load-use bubble
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc    <= `CPU_RESET_PC;
            if_id <= '0;
        end else if (enable) begin
            pc <= pc_next;
            if (redirect.valid) begin
                if_id.valid <= 1'b0;            // Wrong-path fetch
            end else if (!hold) begin
                if_id <= '{valid: 1'b1, pc: pc, instr: rom_data};
            end
        end
    end

endmodule

/* hdl/register_bank.sv */
module register_bank (
    input  logic               clock,
    input  logic               rst_n,
    input  cpu_pkg::retire_t   write,
    input  cpu_pkg::reg_idx_t  read_address1,
    input  cpu_pkg::reg_idx_t  read_address2,
    output cpu_pkg::word_t     value1,
    output cpu_pkg::word_t     value2
);

    cpu_pkg::word_t regs [32];
    logic           write_en;

    assign write_en = write.valid && (write.rd != '0);  // x0 stays zero

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[write.rd] <= write.data;
        end
    end

    // Write-first, so decode sees the value retiring this cycle
    assign value1 = (write_en && write.rd == read_address1) ? write.data : regs[read_address1];
    assign value2 = (write_en && write.rd == read_address2) ? write.data : regs[read_address2];

endmodule

/* hdl/decode.sv */
module decode (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                enable,
    input  cpu_pkg::if_id_t     if_id,
    input  cpu_pkg::redirect_t  redirect,
    input  cpu_pkg::reg_idx_t   ex_load_rd,
    input  logic                ex_load,
    output cpu_pkg::reg_idx_t   read_address1,
    output cpu_pkg::reg_idx_t   read_address2,
    input  cpu_pkg::word_t      value1,
    input  cpu_pkg::word_t      value2,
    output logic                hold,
    output cpu_pkg::id_ex_t     id_ex
);

    cpu_pkg::word_t  instr;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            known;
    logic            uses_rs1;
    logic            uses_rs2;
    cpu_pkg::id_ex_t dec;

    assign instr         = if_id.instr;
    assign funct3        = instr[14:12];
    assign funct7        = instr[31:25];
    assign read_address1 = instr[19:15];
    assign read_address2 = instr[24:20];

    always_comb begin
        dec           = '0;
        dec.pc        = if_id.pc;
        dec.rs1       = read_address1;
        dec.rs2       = read_address2;
        dec.rd        = instr[11:7];
        dec.rs1_value = value1;
        dec.rs2_value = value2;
        dec.alu_op    = cpu_pkg::ALU_ADD;
        dec.wb_sel    = cpu_pkg::WB_ALU;
        known         = 1'b0;
        uses_rs1      = 1'b0;
        uses_rs2      = 1'b0;
        case (instr[6:0])
            cpu_pkg::OPC_LUI: begin
                known = 1'b1;
                dec.reg_write   = 1'b1;
                dec.alu_src_imm = 1'b1;
                dec.alu_op      = cpu_pkg::ALU_PASS_B;
                dec.imm         = {instr[31:12], 12'b0};
            end
            cpu_pkg::OPC_JAL: begin
                known = 1'b1;
                dec.reg_write = 1'b1;
                dec.jump      = 1'b1;
                dec.wb_sel    = cpu_pkg::WB_LINK;
                dec.imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            cpu_pkg::OPC_BRANCH: begin
                known         = (funct3 == 3'b000) || (funct3 == 3'b001);  // BEQ, BNE
                uses_rs1      = 1'b1;
                uses_rs2      = 1'b1;
                dec.branch    = 1'b1;
                dec.branch_ne = funct3[0];
                dec.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            cpu_pkg::OPC_LOAD: begin
                known           = (funct3 == 3'b010);  // LW only
                uses_rs1        = 1'b1;
                dec.reg_write   = 1'b1;
                dec.mem_read    = 1'b1;
                dec.alu_src_imm = 1'b1;
                dec.wb_sel      = cpu_pkg::WB_MEM;
                dec.imm         = {{20{instr[31]}}, instr[31:20]};
            end
            cpu_pkg::OPC_STORE: begin
                known           = (funct3 == 3'b010);  // SW only
                uses_rs1        = 1'b1;
                uses_rs2        = 1'b1;
                dec.mem_write   = 1'b1;
                dec.alu_src_imm = 1'b1;
                dec.imm         = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            cpu_pkg::OPC_OP_IMM: begin
                known           = (funct3 == 3'b000);  // ADDI only
                uses_rs1        = 1'b1;
                dec.reg_write   = 1'b1;
                dec.alu_src_imm = 1'b1;
                dec.imm         = {{20{instr[31]}}, instr[31:20]};
            end
            cpu_pkg::OPC_OP: begin
                known         = 1'b1;
                uses_rs1      = 1'b1;
                uses_rs2      = 1'b1;
                dec.reg_write = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: dec.alu_op = cpu_pkg::ALU_ADD;
                    {7'b0100000, 3'b000}: dec.alu_op = cpu_pkg::ALU_SUB;
                    {7'b0000000, 3'b111}: dec.alu_op = cpu_pkg::ALU_AND;
                    {7'b0000000, 3'b110}: dec.alu_op = cpu_pkg::ALU_OR;
                    {7'b0000000, 3'b100}: dec.alu_op = cpu_pkg::ALU_XOR;
                    {7'b0000000, 3'b010}: dec.alu_op = cpu_pkg::ALU_SLT;
                    default:              known      = 1'b0;
                endcase
            end
            default: known = 1'b0;  // Unsupported opcode becomes a bubble
        endcase
        // Load in execute whose rd feeds this instruction
        hold = if_id.valid && ex_load && (ex_load_rd != '0) &&
               ((uses_rs1 && ex_load_rd == read_address1) ||
                (uses_rs2 && ex_load_rd == read_address2));
        // Squashed, stalled or unknown instructions leave as bubbles
        dec.valid = if_id.valid && known && !hold && !redirect.valid;
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (enable) begin
            id_ex <= dec;
        end
    end

endmodule

/* hdl/execute.sv */
module execute (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                enable,
    input  cpu_pkg::id_ex_t     id_ex,
    input  cpu_pkg::ex_mem_t    fwd_mem,
    input  cpu_pkg::retire_t    fwd_wb,
    output cpu_pkg::redirect_t  redirect,
    output cpu_pkg::ex_mem_t    ex_mem
);

    cpu_pkg::word_t op_a;
    cpu_pkg::word_t op_b;
    cpu_pkg::word_t alu_b;
    cpu_pkg::word_t result;
    cpu_pkg::word_t mem_value;
    logic           mem_fwd_ok;
    logic           taken;

    // Value the instruction in memory will write back
    assign mem_value  = (fwd_mem.wb_sel == cpu_pkg::WB_LINK) ? fwd_mem.link : fwd_mem.result;
    assign mem_fwd_ok = fwd_mem.valid && fwd_mem.reg_write && (fwd_mem.rd != '0);

    function automatic cpu_pkg::word_t forward(
        input cpu_pkg::reg_idx_t idx,
        input cpu_pkg::word_t    reg_value,
        input logic              mem_ok,
        input cpu_pkg::reg_idx_t mem_rd,
        input cpu_pkg::word_t    mem_data,
        input cpu_pkg::retire_t  wb
    );
        if (mem_ok && mem_rd == idx) begin
            return mem_data;                    // Nearer producer wins
        end else if (wb.valid && wb.rd == idx) begin
            return wb.data;                     // Retire never carries x0
        end
        return reg_value;
    endfunction

    assign op_a  = forward(id_ex.rs1, id_ex.rs1_value, mem_fwd_ok, fwd_mem.rd, mem_value, fwd_wb);
    assign op_b  = forward(id_ex.rs2, id_ex.rs2_value, mem_fwd_ok, fwd_mem.rd, mem_value, fwd_wb);
    assign alu_b = id_ex.alu_src_imm ? id_ex.imm : op_b;

    always_comb begin
        case (id_ex.alu_op)
            cpu_pkg::ALU_SUB:    result = op_a - alu_b;
            cpu_pkg::ALU_AND:    result = op_a & alu_b;
            cpu_pkg::ALU_OR:     result = op_a | alu_b;
            cpu_pkg::ALU_XOR:    result = op_a ^ alu_b;
            cpu_pkg::ALU_SLT:    result = {31'b0, $signed(op_a) < $signed(alu_b)};
            cpu_pkg::ALU_PASS_B: result = alu_b;
            default:             result = op_a + alu_b;
        endcase
    end

    // BEQ on equal, BNE on not equal
    assign taken = id_ex.valid &&
                   (id_ex.jump || (id_ex.branch && ((op_a == op_b) != id_ex.branch_ne)));

    assign redirect.valid  = taken;
    assign redirect.target = id_ex.pc + id_ex.imm;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else if (enable) begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.reg_write  <= id_ex.reg_write;
            ex_mem.mem_read   <= id_ex.mem_read;
            ex_mem.mem_write  <= id_ex.mem_write;
            ex_mem.wb_sel     <= id_ex.wb_sel;
            ex_mem.result     <= result;
            ex_mem.store_data <= op_b;
            ex_mem.link       <= id_ex.pc + 32'd4;
        end
    end

endmodule

/* hdl/memory.sv */
`include "cpu_params.svh"

module memory (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              enable,
    input  cpu_pkg::ex_mem_t  ex_mem,
    output cpu_pkg::retire_t  retire
);

    localparam int ADDR_W = $clog2(`CPU_DMEM_WORDS);

    cpu_pkg::word_t    dmem [`CPU_DMEM_WORDS];
    logic [ADDR_W-1:0] index;
    cpu_pkg::word_t    load_data;
    cpu_pkg::word_t    wb_data;

    // Word index, byte offset dropped
    assign index     = ex_mem.result[ADDR_W+`CPU_WORD_OFFSET-1:`CPU_WORD_OFFSET];
    assign load_data = dmem[index];  // Single-cycle read

    always_ff @(posedge clock) begin
        if (enable && ex_mem.valid && ex_mem.mem_write) begin
            dmem[index] <= ex_mem.store_data;
        end
    end

    always_comb begin
        case (ex_mem.wb_sel)
            cpu_pkg::WB_MEM:  wb_data = load_data;
            cpu_pkg::WB_LINK: wb_data = ex_mem.link;
            default:          wb_data = ex_mem.result;
        endcase
    end

    // Register write leaving the pipeline
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            retire <= '0;
        end else if (enable) begin
            retire.valid <= ex_mem.valid && ex_mem.reg_write && (ex_mem.rd != '0);
            retire.rd    <= ex_mem.rd;
            retire.data  <= wb_data;
        end
    end

endmodule

/* hdl/cpu.sv */
module cpu (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              enable,
    output cpu_pkg::word_t    rom_address,
    input  cpu_pkg::word_t    rom_data,
    output cpu_pkg::retire_t  retire
);

    cpu_pkg::if_id_t    if_id;
    cpu_pkg::id_ex_t    id_ex;
    cpu_pkg::ex_mem_t   ex_mem;
    cpu_pkg::redirect_t redirect;
    logic               hold;
    cpu_pkg::reg_idx_t  rb_read_address1;
    cpu_pkg::reg_idx_t  rb_read_address2;
    cpu_pkg::word_t     rb_value1;
    cpu_pkg::word_t     rb_value2;

    fetch i_fetch (
        .clock, .rst_n, .enable,
        .hold, .redirect, .rom_address, .rom_data, .if_id
    );

    decode i_decode (
        .clock, .rst_n, .enable,
        .if_id, .redirect,
        .ex_load_rd    (id_ex.rd),
        .ex_load       (id_ex.valid && id_ex.mem_read),  // Load sitting in execute
        .read_address1 (rb_read_address1),
        .read_address2 (rb_read_address2),
        .value1        (rb_value1),
        .value2        (rb_value2),
        .hold, .id_ex
    );

    register_bank i_register_bank (
        .clock, .rst_n,
        .write         (retire),
        .read_address1 (rb_read_address1),
        .read_address2 (rb_read_address2),
        .value1        (rb_value1),
        .value2        (rb_value2)
    );

    execute i_execute (
        .clock, .rst_n, .enable,
        .id_ex,
        .fwd_mem (ex_mem),
        .fwd_wb  (retire),
        .redirect, .ex_mem
    );

    memory i_memory (.clock, .rst_n, .enable, .ex_mem, .retire);

endmodule

/* tb/tb_cpu.sv */
`include "cpu_params.svh"

module tb_cpu;

    typedef struct packed {
        cpu_pkg::reg_idx_t rd;
        cpu_pkg::word_t    data;
        logic [31:0]       cycle;   // Enabled edges from reset to the retire edge
    } expected_t;

    logic             clock;
    logic             rst_n;
    logic             enable;
    cpu_pkg::word_t   rom_address;
    cpu_pkg::word_t   rom_data;
    cpu_pkg::retire_t retire;

    cpu_pkg::word_t   rom [64];
    int               rom_fill;
    expected_t        expected [$];
    cpu_pkg::retire_t last_retire;
    logic             loaded;       // Retire register was clocked at the last edge
    int               edges;
    int               cycles;
    int               cycle_limit;
    logic [31:0]      lfsr;

    cpu i_cpu (.clock, .rst_n, .enable, .rom_address, .rom_data, .retire);

    assign rom_data = rom[rom_address[5:0]];  // Same-cycle ROM

    always #4 clock = ~clock;

    task automatic stop_run();
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic value_error(input string name, input cpu_pkg::word_t got,
                               input cpu_pkg::word_t want);
        $display("FAILED time=%0t %s got=%h expected=%h", $time, name, got, want);
        stop_run();
    endtask

    task automatic other_error(input string what);
        $display("Error at time %0t: %s", $time, what);
        stop_run();
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // RV32I encoders
    function automatic cpu_pkg::word_t addi(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
    endfunction

    function automatic cpu_pkg::word_t lw(input int rd, input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction

    function automatic cpu_pkg::word_t sw(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic cpu_pkg::word_t rop(input logic [6:0] funct7, input logic [2:0] funct3,
                                           input int rd, input int rs1, input int rs2);
        return {funct7, rs2[4:0], rs1[4:0], funct3, rd[4:0], 7'b0110011};
    endfunction

    function automatic cpu_pkg::word_t lui(input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic cpu_pkg::word_t branch(input logic [2:0] funct3, input int rs1,
                                              input int rs2, input int offset);
        return {offset[12], offset[10:5], rs2[4:0], rs1[4:0], funct3,
                offset[4:1], offset[11], 7'b1100011};
    endfunction

    function automatic cpu_pkg::word_t jal(input int rd, input int offset);
        return {offset[20], offset[10:1], offset[11], offset[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic emit(input cpu_pkg::word_t w);
        rom[rom_fill] = w;
        rom_fill++;
    endtask

    task automatic load_program(input int prog);
        foreach (rom[i]) begin
            rom[i] = '0;
        end
        rom_fill = 0;
        case (prog)
            0: begin                                 // ALU, forwarding and x0
                emit(addi(1, 0, 5));
                emit(addi(2, 0, -3));
                emit(rop(7'b0000000, 3'b000, 3, 1, 2));  // Both sources forwarded
                emit(rop(7'b0100000, 3'b000, 4, 3, 1));
                emit(lui(5, 20'h12345));
                emit(rop(7'b0000000, 3'b111, 6, 5, 2));
                emit(rop(7'b0000000, 3'b110, 7, 6, 4));
                emit(rop(7'b0000000, 3'b100, 8, 7, 5));
                emit(rop(7'b0000000, 3'b010, 9, 2, 1));
                emit(rop(7'b0000000, 3'b010, 10, 1, 2));
                emit(addi(0, 1, 7));                     // Dropped write to x0
                emit(rop(7'b0000000, 3'b000, 11, 0, 1));
            end
            1: begin                                 // Stores, loads, load-use
                emit(addi(1, 0, 'h40));
                emit(addi(2, 0, 'h123));
                emit(sw(2, 1, 0));
                emit(sw(1, 1, 4));
                emit(lw(3, 1, 0));
                emit(lw(4, 1, 4));
                emit(rop(7'b0000000, 3'b000, 5, 3, 4));  // Needs x4 from the load
                emit(lw(6, 1, 0));
                emit(addi(7, 1, 1));
                emit(sw(5, 1, 8));
                emit(lw(8, 1, 8));
                emit(addi(9, 8, 2));
            end
            default: begin                           // Branches and JAL
                emit(addi(1, 0, 1));
                emit(addi(2, 0, 1));
                emit(branch(3'b000, 1, 2, 12));          // Taken BEQ
                emit(addi(3, 0, 99));
                emit(addi(4, 0, 99));
                emit(branch(3'b001, 1, 0, 12));          // Taken BNE
                emit(addi(5, 0, 99));
                emit(addi(6, 0, 99));
                emit(branch(3'b000, 1, 0, 8));
                emit(jal(7, 12));
                emit(addi(8, 0, 99));
                emit(addi(9, 0, 99));
                emit(rop(7'b0000000, 3'b000, 10, 7, 1)); // Uses the link value
                emit(branch(3'b001, 1, 2, 8));
            end
        endcase
        emit(jal(0, 0));  // Park the core
    endtask

    // Sequential ISA model with the pipeline's slot timing
    task automatic build_expected();
        cpu_pkg::word_t    regs [32];
        cpu_pkg::word_t    dmem [`CPU_DMEM_WORDS];
        cpu_pkg::word_t    pc;
        cpu_pkg::word_t    ins;
        cpu_pkg::word_t    a;
        cpu_pkg::word_t    b;
        cpu_pkg::word_t    wdata;
        cpu_pkg::word_t    next_pc;
        cpu_pkg::word_t    imm_i;
        cpu_pkg::reg_idx_t rd;
        cpu_pkg::reg_idx_t load_rd;
        logic [6:0]        opc;
        logic              write;
        logic              uses1;
        logic              uses2;
        int                slot;
        int                count;
        regs    = '{default: '0};
        pc      = `CPU_RESET_PC;
        load_rd = '0;
        slot    = 0;
        count   = 0;
        while (rom[pc[7:2]] != jal(0, 0) && count < 100) begin
            ins     = rom[pc[7:2]];
            opc     = ins[6:0];
            rd      = ins[11:7];
            a       = regs[ins[19:15]];
            b       = regs[ins[24:20]];
            imm_i   = {{20{ins[31]}}, ins[31:20]};
            uses1   = (opc != cpu_pkg::OPC_LUI) && (opc != cpu_pkg::OPC_JAL);
            uses2   = (opc == cpu_pkg::OPC_OP) || (opc == cpu_pkg::OPC_BRANCH) ||
                      (opc == cpu_pkg::OPC_STORE);
            if (load_rd != '0 && ((uses1 && ins[19:15] == load_rd) ||
                                  (uses2 && ins[24:20] == load_rd))) begin
                slot++;                              // Load-use bubble
            end
            load_rd = '0;
            write   = 1'b1;
            wdata   = '0;
            next_pc = pc + 4;
            case (opc)
                cpu_pkg::OPC_OP_IMM: wdata = a + imm_i;
                cpu_pkg::OPC_LUI:    wdata = {ins[31:12], 12'b0};
                cpu_pkg::OPC_LOAD: begin
                    wdata   = dmem[((a + imm_i) >> 2) % `CPU_DMEM_WORDS];
                    load_rd = rd;
                end
                cpu_pkg::OPC_STORE: begin
                    dmem[((a + {{20{ins[31]}}, ins[31:25], ins[11:7]}) >> 2) %
                         `CPU_DMEM_WORDS] = b;
                    write = 1'b0;
                end
                cpu_pkg::OPC_BRANCH: begin
                    write = 1'b0;
                    if ((a == b) != ins[12]) begin
                        next_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                        ins[11:8], 1'b0};
                    end
                end
                cpu_pkg::OPC_JAL: begin
                    wdata   = pc + 4;
                    next_pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                    ins[30:21], 1'b0};
                end
                default: begin
                    case ({ins[30], ins[14:12]})
                        4'b0000: wdata = a + b;
                        4'b1000: wdata = a - b;
                        4'b0111: wdata = a & b;
                        4'b0110: wdata = a | b;
                        4'b0100: wdata = a ^ b;
                        default: wdata = {31'b0, $signed(a) < $signed(b)};
                    endcase
                end
            endcase
            if (write && rd != '0) begin
                regs[rd] = wdata;
                expected.push_back('{rd: rd, data: wdata, cycle: slot + 4});
            end
            slot += (next_pc == pc + 4) ? 1 : 3;  // Redirect costs two slots
            pc = next_pc;
            count++;
        end
        cycle_limit += 4 * count;
    endtask

    task automatic run_program(input int prog, input logic random_enable);
        @(negedge clock);
        rst_n  = 1'b0;
        enable = 1'b1;
        load_program(prog);
        build_expected();
        repeat (10) @(negedge clock);
        assert (rom_address == `CPU_RESET_PC / 4)
            else value_error("rom_address", rom_address, `CPU_RESET_PC / 4);
        rst_n = 1'b1;
        while (expected.size() > 0) begin
            @(negedge clock);
            if (random_enable) begin
                lfsr   = lfsr_step(lfsr);
                enable = lfsr[0];
            end
        end
        enable = 1'b1;
        repeat (8) @(negedge clock);  // Parked, so nothing more may retire
    endtask

    // Retire checker, sees the register values from before this edge
    always @(posedge clock) begin
        expected_t want;
        cycles++;
        if (cycles > cycle_limit) begin
            other_error($sformatf("timeout after %0d cycles", cycles));
        end
        if (!rst_n) begin
            edges  = 0;
            loaded = 1'b0;
        end else begin
            assert (loaded || retire == last_retire)
                else other_error("retire changed while enable was low");
            assert (!retire.valid || edges >= 4)
                else other_error("retire.valid rose before any instruction could finish");
            if (loaded && retire.valid) begin
                assert (expected.size() > 0)
                    else other_error("register write on retire that the program never makes");
                want = expected.pop_front();
                assert (retire.rd == want.rd)
                    else value_error("retire.rd", {27'b0, retire.rd}, {27'b0, want.rd});
                assert (retire.data == want.data)
                    else value_error("retire.data", retire.data, want.data);
                assert (edges == want.cycle)
                    else value_error("retire timing in enabled cycles", edges, want.cycle);
            end
            if (enable) begin
                edges++;
            end
            loaded = enable;
        end
        last_retire = retire;
    end

    initial begin
        clock       = 1'b0;
        rst_n       = 1'b0;
        enable      = 1'b0;
        lfsr        = 32'hf25b_d849;
        cycles      = 0;
        cycle_limit = 200;
        edges       = 0;
        loaded      = 1'b0;
        last_retire = '0;
        rom_fill    = 0;
        // Second pass repeats every program with a random clock enable
        for (int pass = 0; pass < 2; pass++) begin
            for (int prog = 0; prog < 3; prog++) begin
                run_program(prog, pass == 1);
            end
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* sim.f */
+incdir+hdl
hdl/cpu_pkg.sv
hdl/fetch.sv
hdl/register_bank.sv
hdl/decode.sv
hdl/execute.sv
hdl/memory.sv
hdl/cpu.sv
tb/tb_cpu.sv

/* Bender.yml */
package:
  name: cpu

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cpu_pkg.sv
      - hdl/fetch.sv
      - hdl/register_bank.sv
      - hdl/decode.sv
      - hdl/execute.sv
      - hdl/memory.sv
      - hdl/cpu.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - tb/tb_cpu.sv
